/* src/eth_tx_cfg.svh */
`ifndef ETH_TX_CFG_SVH
`define ETH_TX_CFG_SVH

// frame memory
`define ETH_TX_PAYLOAD_DEPTH 256
`define ETH_TX_PAYLOAD_AW    8
`define ETH_TX_LEN_W         9  // holds 1..depth

// host bus
`define ETH_TX_AXI_AW        12

// byte strobe periods in clocks
`define ETH_TX_DIV_100M      10
`define ETH_TX_DIV_10M       100

// sequencer
`define ETH_TX_IFG           12 // idle slots between frames
`define ETH_TX_MAX_REPEAT    7
`define ETH_TX_REPEAT_W      3

`endif

/* src/eth_tx_pkg.sv */
`default_nettype none

`include "eth_tx_cfg.svh"

package eth_tx_pkg;

	// link speed, same coding as the strobe pacer expects
	typedef enum logic [1:0] {
		SPEED_OFF  = 2'b00, // no strobes at all
		SPEED_10M  = 2'b01,
		SPEED_100M = 2'b10,
		SPEED_1G   = 2'b11
	} speed_t;

	// register offsets, payload window sits at 0x100..0x1ff
	typedef enum logic [`ETH_TX_AXI_AW-1:0] {
		REG_CTRL   = 12'h000,
		REG_LEN    = 12'h004,
		REG_REPEAT = 12'h008,
		REG_STATUS = 12'h00C
	} reg_addr_t;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axi_resp_t;

endpackage

`default_nettype wire

/* src/eth_tx_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eth_tx_cfg.svh"

module eth_tx_regs (
	input  logic                          clk125MHz,
	input  logic                          rst_n,
	input  logic [`ETH_TX_AXI_AW-1:0]     s_axil_awaddr,
	input  logic                          s_axil_awvalid,
	output logic                          s_axil_awready,
	input  logic [31:0]                   s_axil_wdata,
	input  logic [3:0]                    s_axil_wstrb,
	input  logic                          s_axil_wvalid,
	output logic                          s_axil_wready,
	output eth_tx_pkg::axi_resp_t         s_axil_bresp,
	output logic                          s_axil_bvalid,
	input  logic                          s_axil_bready,
	input  logic [`ETH_TX_AXI_AW-1:0]     s_axil_araddr,
	input  logic                          s_axil_arvalid,
	output logic                          s_axil_arready,
	output logic [31:0]                   s_axil_rdata,
	output eth_tx_pkg::axi_resp_t         s_axil_rresp,
	output logic                          s_axil_rvalid,
	input  logic                          s_axil_rready,
	output logic                          start_pulse,
	output eth_tx_pkg::speed_t            speed,
	output logic [`ETH_TX_LEN_W-1:0]      frame_len,
	output logic [`ETH_TX_REPEAT_W-1:0]   repeat_count,
	output logic                          mem_we,
	output logic [`ETH_TX_PAYLOAD_AW-1:0] mem_addr,
	output logic [7:0]                    mem_wdata,
	input  logic                          busy,
	input  logic                          frame_done
);
	import eth_tx_pkg::*;

	logic                           wr_go;
	logic                           wr_window;
	logic                           wr_load;
	logic [`ETH_TX_AXI_AW-1:0]      wr_word;
	logic [`ETH_TX_AXI_AW-1:0]      rd_word;
	logic [31:0]                    rd_value;
	logic [7:0]                     frames_sent;
	// lane sequencer for payload words
	logic [3:0]                     lane_strb;
	logic [31:0]                    lane_data;
	logic [`ETH_TX_PAYLOAD_AW-3:0]  lane_word;
	logic [1:0]                     lane_sel;
	logic                           lane_busy;

	// ==================================================
	// write channel
	// ==================================================
	assign lane_busy = |lane_strb;
	assign wr_go     = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid && !lane_busy;
	assign s_axil_awready = wr_go; // aw and w taken together
	assign s_axil_wready  = wr_go;

	assign wr_word   = {s_axil_awaddr[`ETH_TX_AXI_AW-1:2], 2'b00};
	assign wr_window = s_axil_awaddr[`ETH_TX_AXI_AW-1:`ETH_TX_PAYLOAD_AW] == 'h1;
	assign wr_load   = wr_go && wr_window && !busy;

	always_ff @(posedge clk125MHz) begin
		if (!rst_n) begin
			s_axil_bvalid <= 1'b0;
			s_axil_bresp  <= RESP_OKAY;
			start_pulse   <= 1'b0;
			speed         <= SPEED_1G;
			frame_len     <= `ETH_TX_LEN_W'(`ETH_TX_PAYLOAD_DEPTH);
			repeat_count  <= `ETH_TX_REPEAT_W'(1);
			lane_strb     <= 4'b0;
			frames_sent   <= 8'd0;
		end else begin
			start_pulse <= 1'b0;
			if (s_axil_bvalid && s_axil_bready)
				s_axil_bvalid <= 1'b0;
			if (lane_busy)
				lane_strb <= lane_strb & ~(4'b0001 << lane_sel); // one byte per clock
			if (frame_done)
				frames_sent <= frames_sent + 8'd1; // wraps
			if (wr_go) begin
				s_axil_bvalid <= 1'b1;
				s_axil_bresp  <= RESP_OKAY;
				if (wr_window) begin
					if (busy)
						s_axil_bresp <= RESP_SLVERR; // memory locked during a send
					else
						lane_strb <= s_axil_wstrb;
				end else begin
					case (reg_addr_t'(wr_word))
						REG_CTRL: begin
							start_pulse <= s_axil_wdata[0];
							speed       <= speed_t'(s_axil_wdata[2:1]);
						end
						REG_LEN: begin
							if (s_axil_wdata >= 32'd1 &&
							    s_axil_wdata <= 32'(`ETH_TX_PAYLOAD_DEPTH))
								frame_len <= s_axil_wdata[`ETH_TX_LEN_W-1:0];
							else
								s_axil_bresp <= RESP_SLVERR;
						end
						REG_REPEAT: begin
							if (s_axil_wdata >= 32'd1 &&
							    s_axil_wdata <= 32'(`ETH_TX_MAX_REPEAT))
								repeat_count <= s_axil_wdata[`ETH_TX_REPEAT_W-1:0];
							else
								s_axil_bresp <= RESP_SLVERR;
						end
						default: ; // status is read only
					endcase
				end
			end
		end
	end

	always_ff @(posedge clk125MHz) begin
		if (wr_load) begin
			lane_data <= s_axil_wdata;
			lane_word <= s_axil_awaddr[`ETH_TX_PAYLOAD_AW-1:2];
		end
	end

	// lowest pending lane goes first
	always_comb begin
		lane_sel = 2'd0;
		for (int i = 3; i >= 0; i--) begin
			if (lane_strb[i])
				lane_sel = 2'(i);
		end
	end

	assign mem_we    = lane_busy;
	assign mem_addr  = {lane_word, lane_sel};
	assign mem_wdata = lane_data[8*lane_sel +: 8];

	// ==================================================
	// read channel
	// ==================================================
	assign s_axil_arready = s_axil_arvalid && !s_axil_rvalid;
	assign rd_word        = {s_axil_araddr[`ETH_TX_AXI_AW-1:2], 2'b00};

	always_comb begin
		rd_value = 32'd0; // payload window and holes read zero
		case (reg_addr_t'(rd_word))
			REG_CTRL:   rd_value = {29'd0, speed, 1'b0};
			REG_LEN:    rd_value = 32'(frame_len);
			REG_REPEAT: rd_value = 32'(repeat_count);
			REG_STATUS: rd_value = {16'd0, frames_sent, 7'd0, busy};
			default: ;
		endcase
	end

	always_ff @(posedge clk125MHz) begin
		if (!rst_n) begin
			s_axil_rvalid <= 1'b0;
			s_axil_rresp  <= RESP_OKAY;
			s_axil_rdata  <= 32'd0;
		end else begin
			if (s_axil_rvalid && s_axil_rready)
				s_axil_rvalid <= 1'b0;
			if (s_axil_arready) begin
				s_axil_rvalid <= 1'b1;
				s_axil_rresp  <= RESP_OKAY;
				s_axil_rdata  <= rd_value;
			end
		end
	end

endmodule

`default_nettype wire

/* src/frame_source.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eth_tx_cfg.svh"

module frame_source (
	input  logic                          clk125MHz,
	input  logic                          rst_n,
	input  logic                          start_pulse,
	input  eth_tx_pkg::speed_t            speed,
	input  logic [`ETH_TX_LEN_W-1:0]      frame_len,
	input  logic [`ETH_TX_REPEAT_W-1:0]   repeat_count,
	input  logic                          mem_we,
	input  logic [`ETH_TX_PAYLOAD_AW-1:0] mem_addr,
	input  logic [7:0]                    mem_wdata,
	output logic                          busy,
	output logic                          frame_done,
	output logic [7:0]                    data,
	output logic                          valid,
	output logic                          strobe
);
	import eth_tx_pkg::*;

	// crc adds 4 slots and the preamble 8, both taken out of this gap
	localparam int GAP_SLOTS = `ETH_TX_IFG + 12;
	localparam int GAP_W     = $clog2(GAP_SLOTS);
	localparam int DIV_W     = $clog2(`ETH_TX_DIV_10M);

	typedef enum logic [1:0] {ST_IDLE, ST_DATA, ST_GAP} state_t;

	state_t                          state;
	logic [7:0]                      mem [`ETH_TX_PAYLOAD_DEPTH];
	logic [7:0]                      rd_data;
	logic [`ETH_TX_PAYLOAD_AW-1:0]   rd_ptr;
	logic [`ETH_TX_PAYLOAD_AW-1:0]   ptr_d;
	logic [DIV_W-1:0]                div_cnt;
	logic                            tick;
	logic                            last_byte;
	logic [GAP_W-1:0]                gap_cnt;
	logic [`ETH_TX_LEN_W-1:0]        len_q;
	logic [`ETH_TX_REPEAT_W-1:0]     reps_left;

	// ==================================================
	// byte strobe pacing
	// ==================================================
	always_comb begin
		case (speed)
			SPEED_1G:              tick = 1'b1;
			SPEED_100M, SPEED_10M: tick = (div_cnt == '0);
			default:               tick = 1'b0;
		endcase
	end

	always_ff @(posedge clk125MHz) begin
		if (!rst_n) begin
			div_cnt <= '0;
		end else begin
			case (speed)
				SPEED_100M: div_cnt <= (div_cnt >= DIV_W'(`ETH_TX_DIV_100M - 1)) ?
				                       '0 : div_cnt + 1'b1;
				SPEED_10M:  div_cnt <= (div_cnt >= DIV_W'(`ETH_TX_DIV_10M - 1)) ?
				                       '0 : div_cnt + 1'b1;
				default:    div_cnt <= '0;
			endcase
		end
	end

	// ==================================================
	// frame memory, read one cycle ahead of the strobe
	// ==================================================
	assign last_byte = (`ETH_TX_LEN_W'(rd_ptr) == len_q - 1'b1);

	always_comb begin
		ptr_d = rd_ptr;
		if (state == ST_DATA && tick)
			ptr_d = last_byte ? '0 : rd_ptr + 1'b1;
		else if (state == ST_IDLE)
			ptr_d = '0;
	end

	always_ff @(posedge clk125MHz) begin
		if (mem_we)
			mem[mem_addr] <= mem_wdata;
		rd_data <= mem[ptr_d]; // next byte waits here
	end

	// ==================================================
	// sequencer
	// ==================================================
	assign busy = (state != ST_IDLE);

	always_ff @(posedge clk125MHz) begin
		if (!rst_n) begin
			state      <= ST_IDLE;
			rd_ptr     <= '0;
			gap_cnt    <= '0;
			len_q      <= '0;
			reps_left  <= '0;
			data       <= 8'd0;
			valid      <= 1'b0;
			strobe     <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			strobe     <= tick;
			frame_done <= 1'b0;
			rd_ptr     <= ptr_d;
			case (state)
				ST_IDLE: begin
					if (start_pulse) begin
						state     <= ST_DATA;
						len_q     <= frame_len; // settings frozen for the burst
						reps_left <= repeat_count;
					end
				end
				ST_DATA: begin
					if (tick) begin
						data  <= rd_data;
						valid <= 1'b1;
						if (last_byte) begin
							state   <= ST_GAP;
							gap_cnt <= '0;
						end
					end
				end
				ST_GAP: begin
					if (tick) begin
						data       <= 8'd0;
						valid      <= 1'b0;
						frame_done <= (gap_cnt == '0);
						if (gap_cnt == GAP_W'(GAP_SLOTS - 1)) begin
							if (reps_left == `ETH_TX_REPEAT_W'(1)) begin
								state <= ST_IDLE;
							end else begin
								reps_left <= reps_left - 1'b1;
								state     <= ST_DATA;
							end
						end else begin
							gap_cnt <= gap_cnt + 1'b1;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/add_crc32.sv */
`timescale 1ns/1ps
`default_nettype none

module add_crc32 (
	input  logic       clk125MHz,
	input  logic       rst_n,
	input  logic [7:0] data_in,
	input  logic       valid_in,
	input  logic       strobe_in,
	output logic [7:0] data_out,
	output logic       valid_out,
	output logic       strobe_out
);

	// 0x04C11DB7 bit reversed, crc shifts lsb first
	localparam logic [31:0] POLY_REFL = 32'hEDB88320;
	localparam logic [31:0] CRC_INIT  = 32'hFFFFFFFF;

	logic [31:0] crc;
	logic [31:0] fcs;
	logic        frame_open; // payload seen, fcs not yet started
	logic [1:0]  tail;       // fcs byte index

	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		r = c;
		for (int i = 0; i < 8; i++) begin
			if (r[0] ^ d[i])
				r = (r >> 1) ^ POLY_REFL;
			else
				r = r >> 1;
		end
		return r;
	endfunction

	assign fcs = ~crc;

	always_ff @(posedge clk125MHz) begin
		if (!rst_n) begin
			crc        <= CRC_INIT;
			frame_open <= 1'b0;
			tail       <= 2'd0;
			data_out   <= 8'd0;
			valid_out  <= 1'b0;
			strobe_out <= 1'b0;
		end else begin
			strobe_out <= strobe_in;
			if (strobe_in) begin
				if (valid_in) begin
					data_out   <= data_in;
					valid_out  <= 1'b1;
					crc        <= crc_byte(crc, data_in);
					frame_open <= 1'b1;
				end else if (frame_open || tail != 2'd0) begin
					// low byte first
					data_out   <= fcs[8*tail +: 8];
					valid_out  <= 1'b1;
					frame_open <= 1'b0;
					tail       <= tail + 2'd1;
					if (tail == 2'd3)
						crc <= CRC_INIT; // ready for next frame
				end else begin
					data_out  <= 8'd0;
					valid_out <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* src/add_preamble.sv */
`timescale 1ns/1ps
`default_nettype none

module add_preamble (
	input  logic       clk125MHz,
	input  logic       rst_n,
	input  logic [7:0] data_in,
	input  logic       valid_in,
	input  logic       strobe_in,
	output logic [7:0] data_out,
	output logic       valid_out,
	output logic       strobe_out
);

	localparam logic [7:0] PRE_BYTE = 8'h55;
	localparam logic [7:0] SFD_BYTE = 8'hD5;

	logic [7:0] slot_d [8]; // delay line, one slot per strobe
	logic [7:0] slot_v;
	logic       sof;
	logic       pre_active;
	logic [2:0] pre_cnt;

	assign sof = valid_in && !slot_v[0]; // rising valid at the input

	always_ff @(posedge clk125MHz) begin
		if (strobe_in) begin
			slot_d[0] <= data_in;
			for (int i = 1; i < 8; i++) begin
				slot_d[i] <= slot_d[i-1];
			end
		end
	end

	always_ff @(posedge clk125MHz) begin
		if (!rst_n) begin
			slot_v     <= 8'd0;
			pre_active <= 1'b0;
			pre_cnt    <= 3'd0;
			data_out   <= 8'd0;
			valid_out  <= 1'b0;
			strobe_out <= 1'b0;
		end else begin
			strobe_out <= strobe_in;
			if (strobe_in) begin
				slot_v <= {slot_v[6:0], valid_in};
				if (slot_v[7]) begin
					data_out  <= slot_d[7];
					valid_out <= 1'b1;
				end else if (sof) begin
					// first preamble byte
					data_out   <= PRE_BYTE;
					valid_out  <= 1'b1;
					pre_active <= 1'b1;
					pre_cnt    <= 3'd1;
				end else if (pre_active) begin
					data_out  <= (pre_cnt == 3'd7) ? SFD_BYTE : PRE_BYTE;
					valid_out <= 1'b1;
					pre_cnt   <= pre_cnt + 3'd1;
					if (pre_cnt == 3'd7)
						pre_active <= 1'b0;
				end else begin
					data_out  <= 8'd0;
					valid_out <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* src/eth_tx_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eth_tx_cfg.svh"

module eth_tx_top (
	input  logic                      clk125MHz,
	input  logic                      rst_n,
	input  logic [`ETH_TX_AXI_AW-1:0] s_axil_awaddr,
	input  logic                      s_axil_awvalid,
	output logic                      s_axil_awready,
	input  logic [31:0]               s_axil_wdata,
	input  logic [3:0]                s_axil_wstrb,
	input  logic                      s_axil_wvalid,
	output logic                      s_axil_wready,
	output logic [1:0]                s_axil_bresp,
	output logic                      s_axil_bvalid,
	input  logic                      s_axil_bready,
	input  logic [`ETH_TX_AXI_AW-1:0] s_axil_araddr,
	input  logic                      s_axil_arvalid,
	output logic                      s_axil_arready,
	output logic [31:0]               s_axil_rdata,
	output logic [1:0]                s_axil_rresp,
	output logic                      s_axil_rvalid,
	input  logic                      s_axil_rready,
	output logic [7:0]                gmii_txd,
	output logic                      gmii_tx_en,
	output logic                      gmii_strobe
);
	import eth_tx_pkg::*;

	logic                          start_pulse;
	speed_t                        speed;
	logic [`ETH_TX_LEN_W-1:0]      frame_len;
	logic [`ETH_TX_REPEAT_W-1:0]   repeat_count;
	logic                          mem_we;
	logic [`ETH_TX_PAYLOAD_AW-1:0] mem_addr;
	logic [7:0]                    mem_wdata;
	logic                          busy;
	logic                          frame_done;

	// byte stream between stages
	logic [7:0] src_data, crc_data;
	logic       src_valid, crc_valid;
	logic       src_strobe, crc_strobe;

	// ==================================================
	// host side
	// ==================================================
	eth_tx_regs eth_tx_regs_inst (
		.clk125MHz      (clk125MHz),
		.rst_n          (rst_n),
		.s_axil_awaddr  (s_axil_awaddr),
		.s_axil_awvalid (s_axil_awvalid),
		.s_axil_awready (s_axil_awready),
		.s_axil_wdata   (s_axil_wdata),
		.s_axil_wstrb   (s_axil_wstrb),
		.s_axil_wvalid  (s_axil_wvalid),
		.s_axil_wready  (s_axil_wready),
		.s_axil_bresp   (s_axil_bresp),
		.s_axil_bvalid  (s_axil_bvalid),
		.s_axil_bready  (s_axil_bready),
		.s_axil_araddr  (s_axil_araddr),
		.s_axil_arvalid (s_axil_arvalid),
		.s_axil_arready (s_axil_arready),
		.s_axil_rdata   (s_axil_rdata),
		.s_axil_rresp   (s_axil_rresp),
		.s_axil_rvalid  (s_axil_rvalid),
		.s_axil_rready  (s_axil_rready),
		.start_pulse    (start_pulse),
		.speed          (speed),
		.frame_len      (frame_len),
		.repeat_count   (repeat_count),
		.mem_we         (mem_we),
		.mem_addr       (mem_addr),
		.mem_wdata      (mem_wdata),
		.busy           (busy),
		.frame_done     (frame_done)
	);

	// ==================================================
	// framing chain
	// ==================================================
	frame_source frame_source_inst (
		.clk125MHz    (clk125MHz),
		.rst_n        (rst_n),
		.start_pulse  (start_pulse),
		.speed        (speed),
		.frame_len    (frame_len),
		.repeat_count (repeat_count),
		.mem_we       (mem_we),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.busy         (busy),
		.frame_done   (frame_done),
		.data         (src_data),
		.valid        (src_valid),
		.strobe       (src_strobe)
	);

	add_crc32 add_crc32_inst (
		.clk125MHz  (clk125MHz),
		.rst_n      (rst_n),
		.data_in    (src_data),
		.valid_in   (src_valid),
		.strobe_in  (src_strobe),
		.data_out   (crc_data),
		.valid_out  (crc_valid),
		.strobe_out (crc_strobe)
	);

	add_preamble add_preamble_inst (
		.clk125MHz  (clk125MHz),
		.rst_n      (rst_n),
		.data_in    (crc_data),
		.valid_in   (crc_valid),
		.strobe_in  (crc_strobe),
		.data_out   (gmii_txd),
		.valid_out  (gmii_tx_en),
		.strobe_out (gmii_strobe)
	);

endmodule

`default_nettype wire

/* dv/eth_tx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eth_tx_cfg.svh"

module eth_tx_tb;
	import eth_tx_pkg::*;

	localparam logic [31:0] SEED       = 32'hfffb_4abf;
	localparam int          WAIT_LIMIT = 200;  // clocks per handshake
	localparam int          POLL_LIMIT = 1000; // status reads per burst
	localparam logic [`ETH_TX_AXI_AW-1:0] PAYLOAD_BASE = 12'h100;
	localparam logic [31:0] START_1G   = {29'd0, SPEED_1G, 1'b1};
	localparam logic [31:0] SET_100M   = {29'd0, SPEED_100M, 1'b0};
	localparam logic [31:0] START_100M = {29'd0, SPEED_100M, 1'b1};

	logic                      clk125MHz;
	logic                      rst_n;
	logic [`ETH_TX_AXI_AW-1:0] s_axil_awaddr;
	logic                      s_axil_awvalid;
	logic                      s_axil_awready;
	logic [31:0]               s_axil_wdata;
	logic [3:0]                s_axil_wstrb;
	logic                      s_axil_wvalid;
	logic                      s_axil_wready;
	logic [1:0]                s_axil_bresp;
	logic                      s_axil_bvalid;
	logic                      s_axil_bready;
	logic [`ETH_TX_AXI_AW-1:0] s_axil_araddr;
	logic                      s_axil_arvalid;
	logic                      s_axil_arready;
	logic [31:0]               s_axil_rdata;
	logic [1:0]                s_axil_rresp;
	logic                      s_axil_rvalid;
	logic                      s_axil_rready;
	logic [7:0]                gmii_txd;
	logic                      gmii_tx_en;
	logic                      gmii_strobe;

	logic [7:0] payload [$];   // host copy of the frame memory
	logic [7:0] exp_bytes [$];
	// monitor results with one entry per frame
	logic [7:0] rx_bytes [$];
	int         rx_start [$];
	int         rx_len [$];
	int         rx_gap [$];
	bit         in_frame;
	int         idle_slots;
	logic [7:0] prev_txd;
	logic       prev_en;
	bit         pace_check;
	bit         pace_started;
	int         since_strobe;

	eth_tx_top eth_tx_top_inst (
		.clk125MHz      (clk125MHz),
		.rst_n          (rst_n),
		.s_axil_awaddr  (s_axil_awaddr),
		.s_axil_awvalid (s_axil_awvalid),
		.s_axil_awready (s_axil_awready),
		.s_axil_wdata   (s_axil_wdata),
		.s_axil_wstrb   (s_axil_wstrb),
		.s_axil_wvalid  (s_axil_wvalid),
		.s_axil_wready  (s_axil_wready),
		.s_axil_bresp   (s_axil_bresp),
		.s_axil_bvalid  (s_axil_bvalid),
		.s_axil_bready  (s_axil_bready),
		.s_axil_araddr  (s_axil_araddr),
		.s_axil_arvalid (s_axil_arvalid),
		.s_axil_arready (s_axil_arready),
		.s_axil_rdata   (s_axil_rdata),
		.s_axil_rresp   (s_axil_rresp),
		.s_axil_rvalid  (s_axil_rvalid),
		.s_axil_rready  (s_axil_rready),
		.gmii_txd       (gmii_txd),
		.gmii_tx_en     (gmii_tx_en),
		.gmii_strobe    (gmii_strobe)
	);

	initial begin
		clk125MHz = 1'b0;
		forever #4 clk125MHz = ~clk125MHz;
	end

	// ==================================================
	// failure reporting
	// ==================================================
	task automatic abort_run();
		$display("Checks failed");
		$fatal(1, "stopping at first failure");
	endtask

	task automatic report_error(input string msg);
		$display("Error at time %0t: %s", $time, msg);
		abort_run();
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s", what);
		abort_run();
	endtask

	// ==================================================
	// AXI4-Lite host
	// ==================================================
	task automatic write_reg(input logic [`ETH_TX_AXI_AW-1:0] addr, input logic [31:0] value,
	                         output logic [1:0] resp);
		int n;
		@(posedge clk125MHz);
		#1;
		s_axil_awaddr  = addr;
		s_axil_awvalid = 1'b1;
		s_axil_wdata   = value;
		s_axil_wstrb   = 4'hF;
		s_axil_wvalid  = 1'b1;
		n = 0;
		@(negedge clk125MHz); // handshake seen mid cycle and taken at the next edge
		while (!s_axil_awready && !s_axil_wready) begin
			n++;
			if (n > WAIT_LIMIT)
				report_timeout("the AXI write to be accepted");
			@(negedge clk125MHz);
		end
		assert (s_axil_awready && s_axil_wready)
		else report_error("write address and data were not accepted in the same cycle");
		@(posedge clk125MHz);
		#1;
		s_axil_awvalid = 1'b0;
		s_axil_wvalid  = 1'b0;
		s_axil_bready  = 1'b1;
		n = 0;
		@(negedge clk125MHz);
		while (!s_axil_bvalid) begin
			n++;
			if (n > WAIT_LIMIT)
				report_timeout("the AXI write response");
			@(negedge clk125MHz);
		end
		resp = s_axil_bresp;
		@(posedge clk125MHz);
		#1;
		s_axil_bready = 1'b0;
	endtask

	task automatic read_reg(input logic [`ETH_TX_AXI_AW-1:0] addr, output logic [31:0] value);
		int n;
		@(posedge clk125MHz);
		#1;
		s_axil_araddr  = addr;
		s_axil_arvalid = 1'b1;
		n = 0;
		@(negedge clk125MHz);
		while (!s_axil_arready) begin
			n++;
			if (n > WAIT_LIMIT)
				report_timeout("the AXI read address to be accepted");
			@(negedge clk125MHz);
		end
		@(posedge clk125MHz);
		#1;
		s_axil_arvalid = 1'b0;
		s_axil_rready  = 1'b1;
		n = 0;
		@(negedge clk125MHz);
		while (!s_axil_rvalid) begin
			n++;
			if (n > WAIT_LIMIT)
				report_timeout("the AXI read data");
			@(negedge clk125MHz);
		end
		value = s_axil_rdata;
		assert (s_axil_rresp == RESP_OKAY)
		else report_error($sformatf("read of 0x%03h returned response %0d", addr, s_axil_rresp));
		@(posedge clk125MHz);
		#1;
		s_axil_rready = 1'b0;
	endtask

	task automatic write_expect(input logic [`ETH_TX_AXI_AW-1:0] addr, input logic [31:0] value,
	                            input logic [1:0] exp_resp);
		logic [1:0] resp;
		write_reg(addr, value, resp);
		assert (resp == exp_resp)
		else report_error($sformatf("write 0x%08h to 0x%03h gave response %0d, expected %0d",
		                            value, addr, resp, exp_resp));
	endtask

	task automatic read_expect(input logic [`ETH_TX_AXI_AW-1:0] addr, input logic [31:0] value);
		logic [31:0] rd;
		read_reg(addr, rd);
		assert (rd == value)
		else report_error($sformatf("read 0x%08h from 0x%03h, expected 0x%08h", rd, addr, value));
	endtask

	// random bytes into the model and the frame memory as little-endian words
	task automatic load_payload(input int len);
		logic [31:0] word;
		payload.delete();
		for (int i = 0; i < len; i += 4) begin
			for (int k = 0; k < 4; k++)
				payload.push_back(8'($urandom));
			word = {payload[i+3], payload[i+2], payload[i+1], payload[i]};
			write_expect(PAYLOAD_BASE + 12'(i), word, RESP_OKAY);
		end
	endtask

	task automatic wait_idle();
		logic [31:0] st;
		int          n;
		n = 0;
		read_reg(REG_STATUS, st);
		while (st[0]) begin
			n++;
			if (n > POLL_LIMIT)
				report_timeout("busy to clear");
			read_reg(REG_STATUS, st);
		end
	endtask

	task automatic wait_frame_start();
		int n;
		n = 0;
		@(negedge clk125MHz);
		while (!gmii_tx_en) begin
			n++;
			if (n > WAIT_LIMIT)
				report_timeout("a frame to start on the GMII side");
			@(negedge clk125MHz);
		end
	endtask

	task automatic wait_strobe_gap();
		int n;
		n = 0;
		@(negedge clk125MHz);
		while (gmii_strobe) begin
			n++;
			if (n > WAIT_LIMIT)
				report_timeout("a clock without byte strobe");
			@(negedge clk125MHz);
		end
	endtask

	// ==================================================
	// reference model
	// ==================================================
	// msb-first shift register fed lsb first and bit reversed at the end
	function automatic logic [31:0] crc32_of(input logic [7:0] msg [$]);
		logic [31:0] r;
		logic [31:0] out;
		logic [7:0]  d;
		logic        fb;
		r   = 32'hFFFF_FFFF;
		out = 32'h0;
		foreach (msg[n]) begin
			d = msg[n];
			for (int i = 0; i < 8; i++) begin
				fb = r[31] ^ d[0];
				r  = {r[30:0], 1'b0} ^ (fb ? 32'h04C1_1DB7 : 32'h0);
				d  = d >> 1;
			end
		end
		for (int i = 0; i < 32; i++) begin
			out = {out[30:0], r[0]};
			r   = r >> 1;
		end
		return ~out;
	endfunction

	task automatic build_expected(input int len);
		logic [7:0]  body [$];
		logic [31:0] fcs;
		exp_bytes.delete();
		for (int i = 0; i < len; i++)
			body.push_back(payload[i]);
		fcs = crc32_of(body);
		repeat (7) exp_bytes.push_back(8'h55);
		exp_bytes.push_back(8'hD5); // sfd
		foreach (body[i])
			exp_bytes.push_back(body[i]);
		for (int i = 0; i < 4; i++) begin
			exp_bytes.push_back(fcs[7:0]); // low byte first
			fcs = fcs >> 8;
		end
	endtask

	task automatic check_frame(input int idx, input int len);
		assert (rx_len[idx] == 8 + len + 4)
		else report_error($sformatf("frame %0d is %0d slots, expected %0d",
		                            idx, rx_len[idx], 8 + len + 4));
		foreach (exp_bytes[i]) begin
			assert (rx_bytes[rx_start[idx] + i] == exp_bytes[i])
			else report_error($sformatf("frame %0d slot %0d is 0x%02h, expected 0x%02h",
			                            idx, i, rx_bytes[rx_start[idx] + i], exp_bytes[i]));
		end
	endtask

	// ==================================================
	// GMII monitor
	// ==================================================
	always @(negedge clk125MHz) begin
		if (!rst_n) begin
			in_frame   = 1'b0;
			idle_slots = 1000;
			prev_txd   = gmii_txd;
			prev_en    = gmii_tx_en;
		end else begin
			assert (gmii_strobe || (gmii_txd == prev_txd && gmii_tx_en == prev_en))
			else report_error("GMII data or enable changed outside a strobe cycle");
			prev_txd = gmii_txd;
			prev_en  = gmii_tx_en;
			if (gmii_strobe) begin
				if (gmii_tx_en) begin
					if (!in_frame) begin
						rx_start.push_back(rx_bytes.size());
						rx_gap.push_back(idle_slots);
						in_frame = 1'b1;
					end
					rx_bytes.push_back(gmii_txd);
				end else begin
					if (in_frame) begin
						rx_len.push_back(rx_bytes.size() - rx_start[$]);
						in_frame   = 1'b0;
						idle_slots = 0;
					end
					idle_slots++;
				end
			end
			// strobe period check armed only at 100M
			if (pace_check) begin
				since_strobe++;
				if (gmii_strobe) begin
					if (pace_started) begin
						assert (since_strobe == `ETH_TX_DIV_100M)
						else report_error($sformatf("strobe period %0d clocks", since_strobe));
					end
					pace_started = 1'b1;
					since_strobe = 0;
				end
			end else begin
				pace_started = 1'b0;
				since_strobe = 0;
			end
		end
	end

	// ==================================================
	// stimulus
	// ==================================================
	initial begin
		logic [31:0] rd;
		logic [7:0]  check_vec [$];
		int          base_frames;
		int          base_count;
		void'($urandom(SEED));
		rst_n          = 1'b0;
		s_axil_awaddr  = '0;
		s_axil_awvalid = 1'b0;
		s_axil_wdata   = 32'd0;
		s_axil_wstrb   = 4'h0;
		s_axil_wvalid  = 1'b0;
		s_axil_bready  = 1'b0;
		s_axil_araddr  = '0;
		s_axil_arvalid = 1'b0;
		s_axil_rready  = 1'b0;
		pace_check     = 1'b0;
		repeat (8) @(posedge clk125MHz);
		#1;
		rst_n = 1'b1;

		// reference model against the standard check value
		check_vec = '{8'h31, 8'h32, 8'h33, 8'h34, 8'h35, 8'h36, 8'h37, 8'h38, 8'h39};
		assert (crc32_of(check_vec) == 32'hCBF4_3926)
		else report_error("reference CRC-32 disagrees with the check value");

		// after reset
		@(negedge clk125MHz);
		assert (gmii_tx_en == 1'b0) else report_error("gmii_tx_en high after reset");
		read_expect(REG_STATUS, 32'd0);
		read_expect(REG_CTRL, {29'd0, SPEED_1G, 1'b0});

		// register rules
		write_expect(REG_LEN, 32'd64, RESP_OKAY);
		read_expect(REG_LEN, 32'd64);
		write_expect(REG_REPEAT, 32'd2, RESP_OKAY);
		read_expect(REG_REPEAT, 32'd2);
		write_expect(REG_LEN, 32'd0, RESP_SLVERR);
		write_expect(REG_REPEAT, 32'd0, RESP_SLVERR);
		write_expect(REG_REPEAT, 32'd8, RESP_SLVERR);
		read_expect(REG_LEN, 32'd64);
		read_expect(REG_REPEAT, 32'd2);

		// one 64 byte frame at 1G
		write_expect(REG_REPEAT, 32'd1, RESP_OKAY);
		load_payload(64);
		build_expected(64);
		base_frames = rx_len.size();
		write_expect(REG_CTRL, START_1G, RESP_OKAY);
		wait_idle();
		assert (rx_len.size() == base_frames + 1)
		else report_error($sformatf("%0d frames seen, expected 1", rx_len.size() - base_frames));
		check_frame(base_frames, 64);

		// three repeats
		read_reg(REG_STATUS, rd);
		base_count = int'(rd[15:8]);
		write_expect(REG_REPEAT, 32'd3, RESP_OKAY);
		base_frames = rx_len.size();
		write_expect(REG_CTRL, START_1G, RESP_OKAY);
		wait_idle();
		assert (rx_len.size() == base_frames + 3)
		else report_error($sformatf("%0d frames seen, expected 3", rx_len.size() - base_frames));
		for (int f = 0; f < 3; f++)
			check_frame(base_frames + f, 64);
		for (int f = 1; f < 3; f++) begin
			assert (rx_gap[base_frames + f] >= `ETH_TX_IFG)
			else report_error($sformatf("gap of %0d slots before frame %0d",
			                            rx_gap[base_frames + f], base_frames + f));
		end
		read_reg(REG_STATUS, rd);
		assert (rd[0] == 1'b0 && rd[15:8] == 8'(base_count + 3))
		else report_error($sformatf("status 0x%08h after three frames", rd));

		// start and payload writes while busy
		write_expect(REG_REPEAT, 32'd1, RESP_OKAY);
		base_frames = rx_len.size();
		write_expect(REG_CTRL, START_1G, RESP_OKAY);
		wait_frame_start();
		write_expect(PAYLOAD_BASE, 32'hA5A5_A5A5, RESP_SLVERR);
		write_expect(REG_CTRL, START_1G, RESP_OKAY); // source ignores it
		wait_idle();
		assert (rx_len.size() == base_frames + 1)
		else report_error("start while busy produced an extra frame");
		check_frame(base_frames, 64);
		write_expect(REG_CTRL, START_1G, RESP_OKAY);
		wait_idle();
		assert (rx_len.size() == base_frames + 2)
		else report_error("frame after the busy test is missing");
		check_frame(base_frames + 1, 64);

		// 100M pacing with a short frame
		write_expect(REG_CTRL, SET_100M, RESP_OKAY);
		wait_strobe_gap(); // 1G strobes flushed from the chain
		pace_check = 1'b1;
		write_expect(REG_LEN, 32'd16, RESP_OKAY);
		load_payload(16);
		build_expected(16);
		base_frames = rx_len.size();
		write_expect(REG_CTRL, START_100M, RESP_OKAY);
		wait_idle();
		assert (rx_len.size() == base_frames + 1)
		else report_error("no frame at 100M");
		check_frame(base_frames, 16);
		pace_check = 1'b0;

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
+incdir+src
src/eth_tx_pkg.sv
src/eth_tx_regs.sv
src/frame_source.sv
src/add_crc32.sv
src/add_preamble.sv
src/eth_tx_top.sv
dv/eth_tx_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the eth_tx testbench with Verilator.
# The exit status of the simulation binary is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module eth_tx_tb \
	-f build.f \
	-o eth_tx_sim

./obj_dir/eth_tx_sim
